// ==== spi_master_macros.svh ====
`ifndef SPI_MASTER_MACROS_SVH
`define SPI_MASTER_MACROS_SVH

// system clocks per half SCLK period, minus one
`define SPI_CLOCK_DIV 6

// bytes held by one transfer frame
`define SPI_BUFFER_BYTES 16

// bits per byte on the wire
`define SPI_BYTE_BITS 8

// command byte that asks the peer for its status register
`define SPI_STATUS_READ_CMD 8'hAA

`endif

// ==== spi_frame_pkg.sv ====
`default_nettype none

`include "spi_master_macros.svh"

package spi_frame_pkg;

    // one byte on the wire
    typedef logic [`SPI_BYTE_BITS-1:0] spi_byte_t;

    // byte count, 0 up to a full frame
    typedef logic [4:0] byte_count_t;

    // index 0 is the first byte on the wire and sits in the top bits
    typedef logic [0:`SPI_BUFFER_BYTES-1][`SPI_BYTE_BITS-1:0] frame_t;

endpackage

`default_nettype wire

// ==== spi_ctrl_pkg.sv ====
`default_nettype none

package spi_ctrl_pkg;

    // top-level arbiter states
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_USER,
        ARB_STATUS,
        ARB_SIGNALLING
    } arb_state_t;

    // shift engine sequence
    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_EMITTING,
        ENG_RECEIVING,
        ENG_ALIGNING,
        ENG_DONE
    } engine_state_t;

    // current owner of the shift engine
    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_USER,
        GRANT_STATUS
    } grant_t;

endpackage

`default_nettype wire

// ==== spi_clock_divisor.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_clock_divisor #(
    parameter int div = 2
) (
    input  logic clock,
    input  logic reset,
    output logic sclk_rise,
    output logic sclk_fall
);

    localparam int CNT_W = (div > 1) ? $clog2(div + 1) : 1;

    logic [CNT_W-1:0] count;
    logic             phase;

    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
        begin
            count     <= '0;
            phase     <= 1'b0;
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
        end
        else
        begin
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
            if (count == CNT_W'(div))
            begin
                count     <= '0;
                phase     <= ~phase;
                // strobes alternate, half an SCLK period apart
                sclk_rise <= ~phase;
                sclk_fall <= phase;
            end
            else
            begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== spi_emitter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_master_macros.svh"

module spi_emitter (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       enable,
    input  logic                       sclk_rise,
    input  logic                       sclk_fall,
    input  logic                       peer_ready,
    input  spi_frame_pkg::frame_t      data,
    input  spi_frame_pkg::byte_count_t count,
    output logic                       sclk,
    output logic                       sdo,
    output logic                       done,
    output logic                       starting
);

    localparam int BITS_W  = $clog2(`SPI_BUFFER_BYTES * `SPI_BYTE_BITS + 1);
    localparam int PHASE_W = $clog2(`SPI_BYTE_BITS);

    spi_frame_pkg::frame_t latch;
    logic [BITS_W-1:0]     left;
    logic                  loaded;
    logic                  shift_next;
    logic                  at_boundary;
    logic                  accept;

    assign at_boundary = left[PHASE_W-1:0] == '0;
    // a new byte needs the peer ready, later bits never wait
    assign accept = enable && loaded && sclk_rise && left != '0
                    && (!at_boundary || peer_ready);

    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
        begin
            loaded     <= 1'b0;
            left       <= '0;
            sclk       <= 1'b0;
            shift_next <= 1'b0;
            starting   <= 1'b0;
        end
        else
        begin
            starting <= 1'b0;
            if (!enable)
            begin
                loaded     <= 1'b0;
                left       <= '0;
                sclk       <= 1'b0;
                shift_next <= 1'b0;
            end
            else if (!loaded)
            begin
                loaded <= 1'b1;
                left   <= BITS_W'(count * `SPI_BYTE_BITS);
            end
            else if (accept)
            begin
                sclk       <= 1'b1;
                shift_next <= 1'b1;
                starting   <= at_boundary;
            end
            else if (sclk_fall)
            begin
                sclk <= 1'b0;
                if (shift_next)
                begin
                    left       <= left - 1'b1;
                    shift_next <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (enable && !loaded)
            latch <= data;
        else if (sclk_fall && shift_next)
            latch <= latch << 1;
    end

    assign sdo  = loaded && latch[0][`SPI_BYTE_BITS-1];
    assign done = loaded && left == '0;

    a_no_sclk_when_disabled: assert property (
        @(posedge clock) disable iff (!reset)
        $rose(sclk) |-> $past(enable)
    );

endmodule

`default_nettype wire

// ==== spi_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_master_macros.svh"

module spi_receiver (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       enable,
    input  logic                       sclk_rise,
    input  logic                       sclk_fall,
    input  logic                       peer_ready,
    input  logic                       sdi,
    input  spi_frame_pkg::byte_count_t count,
    output logic                       sclk,
    output logic                       done,
    output logic                       starting,
    output spi_frame_pkg::frame_t      data
);

    localparam int BITS_W  = $clog2(`SPI_BUFFER_BYTES * `SPI_BYTE_BITS + 1);
    localparam int PHASE_W = $clog2(`SPI_BYTE_BITS);

    logic [BITS_W-1:0] left;
    logic              loaded;
    logic              shift_next;
    logic              sample;
    logic              at_boundary;
    logic              accept;

    assign at_boundary = left[PHASE_W-1:0] == '0;
    assign accept = enable && loaded && sclk_rise && left != '0
                    && (!at_boundary || peer_ready);

    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
        begin
            loaded     <= 1'b0;
            left       <= '0;
            sclk       <= 1'b0;
            shift_next <= 1'b0;
            starting   <= 1'b0;
        end
        else
        begin
            starting <= 1'b0;
            if (!enable)
            begin
                loaded     <= 1'b0;
                left       <= '0;
                sclk       <= 1'b0;
                shift_next <= 1'b0;
            end
            else if (!loaded)
            begin
                loaded <= 1'b1;
                left   <= BITS_W'(count * `SPI_BYTE_BITS);
            end
            else if (accept)
            begin
                sclk       <= 1'b1;
                shift_next <= 1'b1;
                starting   <= at_boundary;
            end
            else if (sclk_fall)
            begin
                sclk <= 1'b0;
                if (shift_next)
                begin
                    left       <= left - 1'b1;
                    shift_next <= 1'b0;
                end
            end
        end
    end

    // received bits enter at the LSB, so the last byte ends at index 15
    always_ff @(posedge clock)
    begin
        if (accept)
            sample <= sdi;
        if (enable && !loaded)
            data <= '0;
        else if (sclk_fall && shift_next)
            data <= (data << 1) | spi_frame_pkg::frame_t'(sample);
    end

    assign done = loaded && left == '0;

endmodule

`default_nettype wire

// ==== spi_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_master_macros.svh"

module spi_engine (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       start,
    input  logic                       sdi,
    input  logic                       rts,
    input  spi_frame_pkg::frame_t      tx_frame,
    input  spi_frame_pkg::byte_count_t to_write,
    input  spi_frame_pkg::byte_count_t to_read,
    output spi_frame_pkg::frame_t      rx_frame,
    output logic                       done,
    output logic                       sclk,
    output logic                       sdo
);

    spi_ctrl_pkg::engine_state_t state;
    spi_frame_pkg::frame_t       recv_data;
    spi_frame_pkg::byte_count_t  to_shift;
    logic sclk_rise, sclk_fall;
    logic emit_enable, emit_sclk, emit_done, emit_starting;
    logic recv_enable, recv_sclk, recv_done, recv_starting;
    logic rts_q1, rts_q2, peer_ready;

    spi_clock_divisor #(.div(`SPI_CLOCK_DIV)) divisor_i (
        .clock(clock), .reset(reset),
        .sclk_rise(sclk_rise), .sclk_fall(sclk_fall)
    );

    spi_emitter emitter_i (
        .clock(clock), .reset(reset), .enable(emit_enable),
        .sclk_rise(sclk_rise), .sclk_fall(sclk_fall), .peer_ready(peer_ready),
        .data(tx_frame), .count(to_write),
        .sclk(emit_sclk), .sdo(sdo), .done(emit_done), .starting(emit_starting)
    );

    spi_receiver receiver_i (
        .clock(clock), .reset(reset), .enable(recv_enable),
        .sclk_rise(sclk_rise), .sclk_fall(sclk_fall), .peer_ready(peer_ready),
        .sdi(sdi), .count(to_read),
        .sclk(recv_sclk), .done(recv_done), .starting(recv_starting),
        .data(recv_data)
    );

    assign emit_enable = state == spi_ctrl_pkg::ENG_EMITTING;
    assign recv_enable = state == spi_ctrl_pkg::ENG_RECEIVING;
    assign done        = state == spi_ctrl_pkg::ENG_DONE;
    assign sclk        = emit_sclk | recv_sclk;

    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
        begin
            state    <= spi_ctrl_pkg::ENG_IDLE;
            to_shift <= '0;
        end
        else if (!start)
        begin
            state <= spi_ctrl_pkg::ENG_IDLE;
        end
        else
        begin
            case (state)
                spi_ctrl_pkg::ENG_IDLE:
                begin
                    to_shift <= spi_frame_pkg::byte_count_t'(`SPI_BUFFER_BYTES) - to_read;
                    state    <= spi_ctrl_pkg::ENG_EMITTING;
                end
                spi_ctrl_pkg::ENG_EMITTING:
                    if (emit_done)
                        state <= (to_read == '0) ? spi_ctrl_pkg::ENG_DONE
                                                 : spi_ctrl_pkg::ENG_RECEIVING;
                spi_ctrl_pkg::ENG_RECEIVING:
                    if (recv_done)
                        state <= (to_shift == '0) ? spi_ctrl_pkg::ENG_DONE
                                                  : spi_ctrl_pkg::ENG_ALIGNING;
                spi_ctrl_pkg::ENG_ALIGNING:
                begin
                    // one byte per cycle, last shift leads straight to done
                    to_shift <= to_shift - 1'b1;
                    if (to_shift == 5'd1)
                        state <= spi_ctrl_pkg::ENG_DONE;
                end
                default:
                    state <= state;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (emit_enable && emit_done && to_read == '0)
            rx_frame <= '0;
        else if (recv_enable && recv_done)
            rx_frame <= recv_data;
        else if (state == spi_ctrl_pkg::ENG_ALIGNING)
            rx_frame <= rx_frame << `SPI_BYTE_BITS;
    end

    // rts is asynchronous to us, a low pulse marks the peer as ready
    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
        begin
            rts_q1     <= 1'b1;
            rts_q2     <= 1'b1;
            peer_ready <= 1'b0;
        end
        else
        begin
            rts_q1 <= rts;
            rts_q2 <= rts_q1;
            if (rts_q2 && !rts_q1)
                peer_ready <= 1'b1;
            else if (emit_starting || recv_starting)
                peer_ready <= 1'b0;
        end
    end

    a_one_shifter_active: assert property (
        @(posedge clock) disable iff (!reset)
        !((emit_enable || emit_sclk) && (recv_enable || recv_sclk))
    );

endmodule

`default_nettype wire

// ==== spi_user_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_user_port (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       enable,
    input  logic                       grant_done,
    input  spi_frame_pkg::frame_t      out_frame,
    input  spi_frame_pkg::frame_t      rx_frame,
    input  spi_frame_pkg::byte_count_t to_write,
    input  spi_frame_pkg::byte_count_t to_read,
    input  logic                       irq_clear,
    output logic                       request,
    output spi_frame_pkg::frame_t      req_frame,
    output spi_frame_pkg::byte_count_t req_write,
    output spi_frame_pkg::byte_count_t req_read,
    output spi_frame_pkg::frame_t      in_frame,
    output logic                       irq
);

    // request stays up for as long as enable does
    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
        begin
            request <= 1'b0;
            irq     <= 1'b0;
        end
        else
        begin
            request <= enable;
            if (grant_done)
                irq <= 1'b1;
            else if (irq_clear)
                irq <= 1'b0;
        end
    end

    // capture the user buffer as enable rises
    always_ff @(posedge clock)
    begin
        if (enable && !request)
        begin
            req_frame <= out_frame;
            req_write <= to_write;
            req_read  <= to_read;
        end
        if (grant_done)
            in_frame <= rx_frame;
    end

endmodule

`default_nettype wire

// ==== spi_status_poller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_master_macros.svh"

module spi_status_poller (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     picintr,
    input  logic                     statusread,
    input  logic                     grant_done,
    input  logic                     stale,
    input  spi_frame_pkg::frame_t    rx_frame,
    output logic                     pending,
    output spi_frame_pkg::spi_byte_t status,
    output logic                     statusirq
);

    spi_frame_pkg::spi_byte_t new_status;
    logic last_picintr, last_statusread;
    logic poll_event;
    logic requeue;

    assign poll_event = (picintr != last_picintr) || stale;
    assign new_status = {1'b1, rx_frame[0][`SPI_BYTE_BITS-2:0]};

    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
        begin
            last_picintr    <= 1'b0;
            last_statusread <= 1'b0;
            pending         <= 1'b0;
            requeue         <= 1'b0;
            status          <= '0;
            statusirq       <= 1'b0;
        end
        else
        begin
            last_picintr    <= picintr;
            last_statusread <= statusread;

            // a change seen while a poll is queued forces one more poll
            if (grant_done)
            begin
                pending <= requeue || poll_event;
                requeue <= 1'b0;
            end
            else if (poll_event)
            begin
                pending <= 1'b1;
                requeue <= pending;
            end

            if (stale)
                status[`SPI_BYTE_BITS-1] <= 1'b0;

            if (statusread != last_statusread)
                statusirq <= 1'b0;
            if (grant_done)
            begin
                status <= new_status;
                if (new_status != status)
                    statusirq <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== spi_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_master_macros.svh"

module spi_arbiter (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       enable,
    input  logic                       user_request,
    input  logic                       user_irq,
    input  logic                       poll_pending,
    input  logic                       engine_done,
    input  spi_frame_pkg::frame_t      user_frame,
    input  spi_frame_pkg::byte_count_t user_write,
    input  spi_frame_pkg::byte_count_t user_read,
    output logic                       engine_start,
    output spi_frame_pkg::frame_t      tx_frame,
    output spi_frame_pkg::byte_count_t to_write,
    output spi_frame_pkg::byte_count_t to_read,
    output logic                       user_done,
    output logic                       poll_done,
    output logic                       stale,
    output logic                       irq_clear
);

    spi_ctrl_pkg::arb_state_t state;
    spi_ctrl_pkg::grant_t     owner;
    logic user_win, poll_win;

    // user first, but not while its previous irq is still up
    assign user_win = state == spi_ctrl_pkg::ARB_IDLE && user_request && !user_irq;
    assign poll_win = state == spi_ctrl_pkg::ARB_IDLE && !user_win && poll_pending;

    assign stale        = user_win;
    assign irq_clear    = poll_win;
    assign engine_start = owner != spi_ctrl_pkg::GRANT_NONE;
    assign user_done    = engine_done && owner == spi_ctrl_pkg::GRANT_USER;
    assign poll_done    = engine_done && owner == spi_ctrl_pkg::GRANT_STATUS;

    always_ff @(posedge clock or negedge reset)
    begin
        if (!reset)
        begin
            state <= spi_ctrl_pkg::ARB_IDLE;
            owner <= spi_ctrl_pkg::GRANT_NONE;
        end
        else
        begin
            case (state)
                spi_ctrl_pkg::ARB_IDLE:
                    if (user_win)
                    begin
                        state <= spi_ctrl_pkg::ARB_USER;
                        owner <= spi_ctrl_pkg::GRANT_USER;
                    end
                    else if (poll_win)
                    begin
                        state <= spi_ctrl_pkg::ARB_STATUS;
                        owner <= spi_ctrl_pkg::GRANT_STATUS;
                    end
                spi_ctrl_pkg::ARB_USER:
                    if (user_done)
                    begin
                        state <= spi_ctrl_pkg::ARB_SIGNALLING;
                        owner <= spi_ctrl_pkg::GRANT_NONE;
                    end
                spi_ctrl_pkg::ARB_STATUS:
                    if (poll_done)
                    begin
                        state <= spi_ctrl_pkg::ARB_IDLE;
                        owner <= spi_ctrl_pkg::GRANT_NONE;
                    end
                default:
                    // signalling holds until the user drops enable
                    if (!enable)
                        state <= spi_ctrl_pkg::ARB_IDLE;
            endcase
        end
    end

    always_comb
    begin
        if (owner == spi_ctrl_pkg::GRANT_STATUS)
        begin
            tx_frame    = '0;
            tx_frame[0] = `SPI_STATUS_READ_CMD;
            to_write    = 5'd1;
            to_read     = 5'd1;
        end
        else
        begin
            tx_frame = user_frame;
            to_write = user_write;
            to_read  = user_read;
        end
    end

    a_single_done: assert property (
        @(posedge clock) disable iff (!reset)
        (user_done || poll_done) |=> !(user_done || poll_done)
    );

endmodule

`default_nettype wire

// ==== spi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_master (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       enable,
    input  spi_frame_pkg::frame_t      out_frame,
    input  spi_frame_pkg::byte_count_t to_write,
    input  spi_frame_pkg::byte_count_t to_read,
    input  logic                       sdi,
    input  logic                       rts,
    input  logic                       picintr,
    input  logic                       statusread,
    output logic                       sclk,
    output logic                       sdo,
    output logic                       irq,
    output spi_frame_pkg::frame_t      in_frame,
    output spi_frame_pkg::spi_byte_t   status,
    output logic                       statusirq
);

    spi_frame_pkg::frame_t      user_frame, tx_frame, rx_frame;
    spi_frame_pkg::byte_count_t user_write, user_read, eng_write, eng_read;
    logic user_request, poll_pending, engine_start, engine_done;
    logic user_done, poll_done, stale, irq_clear;

    spi_user_port user_port_i (
        .clock(clock), .reset(reset), .enable(enable), .grant_done(user_done),
        .out_frame(out_frame), .rx_frame(rx_frame),
        .to_write(to_write), .to_read(to_read), .irq_clear(irq_clear),
        .request(user_request), .req_frame(user_frame),
        .req_write(user_write), .req_read(user_read),
        .in_frame(in_frame), .irq(irq)
    );

    spi_status_poller status_poller_i (
        .clock(clock), .reset(reset), .picintr(picintr), .statusread(statusread),
        .grant_done(poll_done), .stale(stale), .rx_frame(rx_frame),
        .pending(poll_pending), .status(status), .statusirq(statusirq)
    );

    spi_arbiter arbiter_i (
        .clock(clock), .reset(reset), .enable(enable),
        .user_request(user_request), .user_irq(irq), .poll_pending(poll_pending),
        .engine_done(engine_done), .user_frame(user_frame),
        .user_write(user_write), .user_read(user_read),
        .engine_start(engine_start), .tx_frame(tx_frame),
        .to_write(eng_write), .to_read(eng_read),
        .user_done(user_done), .poll_done(poll_done),
        .stale(stale), .irq_clear(irq_clear)
    );

    spi_engine engine_i (
        .clock(clock), .reset(reset), .start(engine_start),
        .sdi(sdi), .rts(rts), .tx_frame(tx_frame),
        .to_write(eng_write), .to_read(eng_read), .rx_frame(rx_frame),
        .done(engine_done), .sclk(sclk), .sdo(sdo)
    );

endmodule

`default_nettype wire

// ==== tb_spi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_master_macros.svh"

module tb_spi_master;

    localparam int TIMEOUT_CYCLES = 20 * 34 * 160;
    // last SCLK half period, 15 alignment cycles and the status register update
    localparam int DRAIN_CYCLES = `SPI_CLOCK_DIV + 1 + `SPI_BUFFER_BYTES + 4;

    logic clock, reset, enable, sdi, rts, picintr, statusread;
    logic sclk, sdo, irq, statusirq;
    spi_frame_pkg::frame_t      out_frame, in_frame;
    spi_frame_pkg::byte_count_t to_write, to_read;
    spi_frame_pkg::spi_byte_t   status;

    // expected state of the transfer in flight
    spi_frame_pkg::frame_t cur_frame;
    int         cur_write, cur_read;
    logic [7:0] peer_status, exp_status;
    logic       exp_irq;
    int         errors = 0;
    int         transfers = 0;
    int         polls = 0;

    // peer side of the link
    logic       sclk_q = 1'b0;
    logic       irq_q = 1'b0;
    logic [7:0] peer_shift, peer_answer, peer_first;
    logic [7:0] peer_cap [0:15];
    int         peer_bits = 0;
    int         peer_idx = 0;
    int         peer_wr = 1;
    int         bytes_seen = 0;
    int         rts_pulses = 0;

    spi_master spi_master_i (
        .clock(clock), .reset(reset), .enable(enable),
        .out_frame(out_frame), .to_write(to_write), .to_read(to_read),
        .sdi(sdi), .rts(rts), .picintr(picintr), .statusread(statusread),
        .sclk(sclk), .sdo(sdo), .irq(irq), .in_frame(in_frame),
        .status(status), .statusirq(statusirq)
    );

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // read byte k is the first written byte plus 17 k, zero beyond to_read
    function automatic spi_frame_pkg::frame_t expected_frame(input logic [7:0] first,
                                                             input int rd);
        spi_frame_pkg::frame_t f;
        int k;
        f = '0;
        for (k = 0; k < rd; k++)
            f[k] = first + 8'(17 * k);
        return f;
    endfunction

    task automatic report_mismatch(input string what);
        errors++;
        $display("[ERROR] %0t ns: %s", $time, what);
    endtask

    task automatic arm_peer(input int wr);
        peer_wr  <= wr;
        peer_idx <= 0;
    endtask

    // a poll stores bit 7 set plus the low status bits, irq only on change
    task automatic poll_model();
        logic [7:0] fresh;
        fresh = {1'b1, peer_status[6:0]};
        if (fresh != exp_status)
            exp_irq = 1'b1;
        exp_status = fresh;
        polls++;
    endtask

    task automatic check_status();
        assert (status === exp_status)
        else
            report_mismatch($sformatf("status %h, expected %h", status, exp_status));
        assert (statusirq === exp_irq)
        else
            report_mismatch($sformatf("statusirq %b, expected %b", statusirq, exp_irq));
    endtask

    task automatic clear_statusirq();
        int n;
        @(posedge clock);
        statusread <= ~statusread;
        exp_irq = 1'b0;
        for (n = 0; n < 8 && statusirq; n++)
            @(posedge clock);
        assert (statusirq === 1'b0)
        else
            report_mismatch("statusirq still high after statusread toggle");
    endtask

    task automatic run_user_request(input int wr, input int rd);
        spi_frame_pkg::frame_t f;
        int i;
        int n;
        int hold;
        for (i = 0; i < `SPI_BUFFER_BYTES; i++)
            f[i] = 8'($urandom);
        // keep user traffic apart from the status command
        if (f[0] == `SPI_STATUS_READ_CMD)
            f[0] = 8'h5A;
        cur_frame = f;
        cur_write = wr;
        cur_read  = rd;
        @(posedge clock);
        arm_peer(wr);
        out_frame <= f;
        to_write  <= spi_frame_pkg::byte_count_t'(wr);
        to_read   <= spi_frame_pkg::byte_count_t'(rd);
        enable    <= 1'b1;
        exp_status[7] = 1'b0;
        while (!irq)
            @(posedge clock);
        assert (status[7] === 1'b0)
        else
            report_mismatch("status bit 7 not cleared by the user transfer");
        hold = $urandom_range(10, 2);
        for (n = 0; n < hold; n++)
        begin
            @(posedge clock);
            assert (irq === 1'b1)
            else
                report_mismatch("irq fell while enable was high");
        end
        arm_peer(1);
        enable <= 1'b0;
        for (n = 0; n < 8 && irq; n++)
            @(posedge clock);
        assert (irq === 1'b0)
        else
            report_mismatch("irq still high after enable dropped");
        while (!status[7])
            @(posedge clock);
        poll_model();
        check_status();
        clear_statusirq();
    endtask

    task automatic run_picintr_poll();
        // about half the polls leave the status unchanged
        if ($urandom_range(1, 0) == 1)
            peer_status = 8'($urandom);
        @(posedge clock);
        arm_peer(1);
        picintr <= ~picintr;
        do
            @(posedge clock);
        while (peer_idx < 2);
        repeat (DRAIN_CYCLES) @(posedge clock);
        poll_model();
        check_status();
        clear_statusirq();
    endtask

    // peer shifts sdo in on each sclk rise and answers on sdi MSB first
    always @(posedge clock)
    begin : peer_model
        logic [7:0] got;
        logic [7:0] first;
        logic [7:0] reply;
        got   = {peer_shift[6:0], sdo};
        first = (peer_idx == 0) ? got : peer_first;
        sclk_q <= sclk;
        if (sclk && !sclk_q)
        begin
            peer_shift <= got;
            // a byte may only begin once an rts pulse has been sent for it
            if (peer_bits == 0)
            begin
                assert (bytes_seen < rts_pulses)
                else
                    report_mismatch($sformatf("byte %0d started after %0d rts pulses",
                                              bytes_seen + 1, rts_pulses));
            end
            if (peer_bits < 7)
            begin
                peer_bits <= peer_bits + 1;
                if (peer_idx >= peer_wr)
                    sdi <= peer_answer[6 - peer_bits];
            end
            else
            begin
                peer_bits  <= 0;
                peer_idx   <= peer_idx + 1;
                bytes_seen <= bytes_seen + 1;
                if (peer_idx < peer_wr)
                    peer_cap[peer_idx] <= got;
                if (peer_idx == 0)
                    peer_first <= got;
                // next byte is a read, put its MSB out before the first rise
                if (peer_idx + 1 >= peer_wr)
                begin
                    if (first == `SPI_STATUS_READ_CMD)
                        reply = peer_status;
                    else
                        reply = first + 8'(17 * (peer_idx + 1 - peer_wr));
                    peer_answer <= reply;
                    sdi <= reply[7];
                end
            end
        end
    end

    // one low pulse on rts per byte, after a random gap
    initial
    begin : rts_pulser
        int gap;
        int seen;
        wait (reset === 1'b1);
        forever
        begin
            gap = $urandom_range(20, 0);
            repeat (gap) @(posedge clock);
            @(posedge clock);
            rts <= 1'b0;
            rts_pulses++;
            repeat (2) @(posedge clock);
            rts <= 1'b1;
            seen = bytes_seen;
            while (bytes_seen == seen)
                @(posedge clock);
        end
    end

    always @(posedge clock)
    begin : compare_results
        spi_frame_pkg::frame_t expected;
        int i;
        irq_q <= irq;
        if (irq && !irq_q)
        begin
            expected = expected_frame(cur_frame[0], cur_read);
            transfers++;
            assert (in_frame === expected)
            else
                report_mismatch($sformatf("in_frame %h, expected %h", in_frame, expected));
            assert (peer_idx == cur_write + cur_read)
            else
                report_mismatch($sformatf("peer saw %0d bytes, expected %0d",
                                          peer_idx, cur_write + cur_read));
            for (i = 0; i < cur_write; i++)
                assert (peer_cap[i] === cur_frame[i])
                else
                    report_mismatch($sformatf("peer byte %0d is %h, expected %h",
                                              i, peer_cap[i], cur_frame[i]));
        end
    end

    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clock);
            cycles++;
        end
        $display("Run timed out after %0d clock cycles without finishing", cycles);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin : stimulus
        int n;
        int wr;
        int rd;
        void'($urandom(71195));
        reset      = 1'b0;
        enable     = 1'b0;
        out_frame  = '0;
        to_write   = '0;
        to_read    = '0;
        sdi        = 1'b0;
        rts        = 1'b1;
        picintr    = 1'b0;
        statusread = 1'b0;
        peer_status = 8'($urandom);
        exp_status  = 8'h00;
        exp_irq     = 1'b0;
        repeat (4) @(posedge clock);
        reset <= 1'b1;
        @(posedge clock);
        assert (sclk === 1'b0 && sdo === 1'b0 && irq === 1'b0 && statusirq === 1'b0)
        else
            report_mismatch("sclk, sdo, irq or statusirq not low after reset");
        assert (status === 8'h00)
        else
            report_mismatch($sformatf("status %h after reset, expected 00", status));

        for (n = 0; n < 20; n++)
        begin
            if (n % 3 == 2)
            begin
                run_picintr_poll();
            end
            else
            begin
                wr = $urandom_range(16, 1);
                rd = (n % 4 == 0) ? 0 : $urandom_range(16, 1);
                run_user_request(wr, rd);
            end
        end

        $display("transfers checked %0d, polls checked %0d, errors %0d",
                 transfers, polls, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
spi_frame_pkg.sv
spi_ctrl_pkg.sv
spi_clock_divisor.sv
spi_emitter.sv
spi_receiver.sv
spi_engine.sv
spi_user_port.sv
spi_status_poller.sv
spi_arbiter.sv
spi_master.sv
tb_spi_master.sv

// ==== Bender.yml ====
package:
  name: spi_master

sources:
  - include_dirs:
      - .
    files:
      - spi_frame_pkg.sv
      - spi_ctrl_pkg.sv
      - spi_clock_divisor.sv
      - spi_emitter.sv
      - spi_receiver.sv
      - spi_engine.sv
      - spi_user_port.sv
      - spi_status_poller.sv
      - spi_arbiter.sv
      - spi_master.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_spi_master.sv
